//--- rtl/udp_tx_pkg.sv
package udp_tx_pkg;

    // ********************
    // widths
    // ********************
    typedef logic [7:0]  byte_t;   // gmii / frame byte
    typedef logic [31:0] word_t;   // payload word and header word
    typedef logic [15:0] len_t;    // byte counts and length fields
    typedef logic [47:0] mac_t;
    typedef logic [31:0] ip_t;
    typedef logic [31:0] crc_t;

    // frame segments in transmit order
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CHECK_SUM,
        ST_PREAMBLE,
        ST_ETH_HEAD,
        ST_IP_HEAD,
        ST_TX_DATA,
        ST_CRC
    } frame_state_t;

    // ********************
    // addresses
    // ********************
    localparam mac_t BOARD_MAC       = 48'h00_11_22_33_44_55;
    localparam ip_t  BOARD_IP        = {8'd192, 8'd168, 8'd1, 8'd10};
    localparam mac_t DEFAULT_DES_MAC = 48'hff_ff_ff_ff_ff_ff;   // broadcast
    localparam ip_t  DEFAULT_DES_IP  = {8'd192, 8'd168, 8'd1, 8'd102};

    // ********************
    // protocol fields
    // ********************
    localparam len_t  ETH_TYPE_IP  = 16'h0800;
    localparam byte_t IP_VER_IHL   = 8'h45;      // v4, 5 words
    localparam len_t  IP_FLAGS_DF  = 16'h4000;   // don't fragment, offset 0
    localparam byte_t IP_TTL       = 8'h40;
    localparam byte_t UDP_PROTO    = 8'd17;
    localparam len_t  UDP_PORT     = 16'd1234;   // source and destination
    // 46 byte minimum eth payload minus ip and udp headers
    localparam len_t  MIN_DATA_NUM = 16'd18;
    localparam len_t  IP_HEAD_LEN  = 16'd20;
    localparam len_t  UDP_HEAD_LEN = 16'd8;

    // segment sizes in bytes, ip head in words
    localparam int PREAMBLE_LEN  = 8;
    localparam int ETH_HEAD_LEN  = 14;
    localparam int IP_HEAD_WORDS = 7;   // 5 ip + 2 udp
    localparam int FCS_LEN       = 4;

    localparam byte_t SFD_BYTE      = 8'hd5;
    localparam byte_t PREAMBLE_BYTE = 8'h55;

    // 0x04C11DB7 bit reversed, for the lsb first crc
    localparam crc_t CRC_POLY_REFL = 32'hedb8_8320;

endpackage

//--- rtl/ip_header_gen.sv
module ip_header_gen (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  udp_tx_pkg::len_t  tx_byte_num,
    input  udp_tx_pkg::mac_t  des_mac,
    input  udp_tx_pkg::ip_t   des_ip,
    input  logic [2:0]        hdr_sel,
    output udp_tx_pkg::word_t hdr_word,
    output udp_tx_pkg::mac_t  dst_mac,
    output udp_tx_pkg::len_t  data_num,
    output logic              hdr_ready
);
    import udp_tx_pkg::*;

    word_t      hdr_mem [IP_HEAD_WORDS];   // ip words 0..4, udp words 5..6
    len_t       ip_id;                     // identification counter
    logic       calc_on;
    logic [1:0] calc_cnt;
    word_t      check_sum;
    word_t      sum_all;
    logic       load;

    // no relatch while a header is being finished
    assign load = start && !calc_on && !hdr_ready;

    // ones complement sum over the ip header halves
    always_comb begin
        sum_all = '0;
        for (int i = 0; i < int'(IP_HEAD_LEN) / 4; i++) begin
            sum_all = sum_all + word_t'(hdr_mem[i][31:16]) + word_t'(hdr_mem[i][15:0]);
        end
    end

    // ********************
    // control
    // ********************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ip_id     <= '0;
            calc_on   <= 1'b0;
            calc_cnt  <= 2'd0;
            hdr_ready <= 1'b0;
        end else begin
            hdr_ready <= 1'b0;
            if (load) begin
                ip_id    <= ip_id + 16'd1;
                calc_on  <= 1'b1;
                calc_cnt <= 2'd0;
            end else if (calc_on) begin
                calc_cnt <= calc_cnt + 2'd1;
                if (calc_cnt == 2'd3) begin
                    calc_on   <= 1'b0;
                    hdr_ready <= 1'b1;   // checksum written this edge
                end
            end
        end
    end

    // ********************
    // header words
    // ********************
    always_ff @(posedge clk) begin
        if (load) begin
            data_num   <= tx_byte_num;
            dst_mac    <= (des_mac != '0) ? des_mac : DEFAULT_DES_MAC;
            hdr_mem[0] <= {IP_VER_IHL, 8'h00, tx_byte_num + IP_HEAD_LEN + UDP_HEAD_LEN};
            hdr_mem[1] <= {ip_id + 16'd1, IP_FLAGS_DF};
            hdr_mem[2] <= {IP_TTL, UDP_PROTO, 16'h0000};   // checksum filled in later
            hdr_mem[3] <= BOARD_IP;
            hdr_mem[4] <= (des_ip != '0) ? des_ip : DEFAULT_DES_IP;
            hdr_mem[5] <= {UDP_PORT, UDP_PORT};
            hdr_mem[6] <= {tx_byte_num + UDP_HEAD_LEN, 16'h0000};   // udp checksum unused
        end else if (calc_on) begin
            case (calc_cnt)
                2'd0:       check_sum <= sum_all;
                // fold carry
                2'd1, 2'd2: check_sum <= word_t'(check_sum[31:16]) + word_t'(check_sum[15:0]);
                default:    hdr_mem[2][15:0] <= ~check_sum[15:0];
            endcase
        end
    end

    assign hdr_word = (hdr_sel < 3'(IP_HEAD_WORDS)) ? hdr_mem[hdr_sel] : '0;

endmodule

//--- rtl/eth_crc32.sv
module eth_crc32 (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              crc_en,
    input  logic              crc_clr,
    input  udp_tx_pkg::byte_t crc_byte,
    output udp_tx_pkg::crc_t  crc_value
);
    import udp_tx_pkg::*;

    crc_t crc_q;
    crc_t crc_nxt;

    // reflected crc, one byte per enable, lsb of the byte first
    always_comb begin
        crc_nxt = crc_q ^ crc_t'(crc_byte);
        for (int i = 0; i < 8; i++) begin
            if (crc_nxt[0]) begin
                crc_nxt = (crc_nxt >> 1) ^ CRC_POLY_REFL;
            end else begin
                crc_nxt = crc_nxt >> 1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc_q <= '1;
        end else if (crc_clr) begin
            crc_q <= '1;   // ready for the next frame
        end else if (crc_en) begin
            crc_q <= crc_nxt;
        end
    end

    // running value, the fsm inverts it for the fcs
    assign crc_value = crc_q;

endmodule

//--- rtl/udp_frame_fsm.sv
module udp_frame_fsm (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              hdr_ready,
    input  udp_tx_pkg::word_t hdr_word,
    input  udp_tx_pkg::mac_t  dst_mac,
    input  udp_tx_pkg::len_t  data_num,
    input  udp_tx_pkg::word_t tx_data,
    input  udp_tx_pkg::crc_t  crc_value,
    output logic [2:0]        hdr_sel,
    output logic              busy,
    output logic              tx_req,
    output logic              tx_done,
    output logic              gmii_tx_en,
    output udp_tx_pkg::byte_t gmii_txd,
    output logic              crc_en,
    output udp_tx_pkg::byte_t crc_byte,
    output logic              crc_clr
);
    import udp_tx_pkg::*;

    frame_state_t                  state;        // segment of the byte on gmii_txd
    frame_state_t                  next_state;
    logic [4:0]                    byte_cnt;     // index in preamble/eth/ip/fcs
    logic [4:0]                    cnt_nxt;
    len_t                          data_cnt;     // payload + pad index
    len_t                          dcnt_nxt;
    len_t                          real_num;
    logic [1:0]                    byte_sel;
    logic                          seg_last;
    logic                          seg_change;
    byte_t                         txd_nxt;
    logic                          req_nxt;
    logic                          done_nxt;
    logic [8*ETH_HEAD_LEN-1:0]     eth_hdr;

    assign real_num = (data_num >= MIN_DATA_NUM) ? data_num : MIN_DATA_NUM;
    assign eth_hdr  = {dst_mac, BOARD_MAC, ETH_TYPE_IP};

    // ********************
    // next state
    // ********************
    always_comb begin
        case (state)
            ST_PREAMBLE: seg_last = (byte_cnt == 5'(PREAMBLE_LEN - 1));
            ST_ETH_HEAD: seg_last = (byte_cnt == 5'(ETH_HEAD_LEN - 1));
            ST_IP_HEAD:  seg_last = (byte_cnt == 5'(IP_HEAD_WORDS * 4 - 1));
            ST_TX_DATA:  seg_last = (data_cnt == real_num - 16'd1);
            ST_CRC:      seg_last = (byte_cnt == 5'(FCS_LEN - 1));
            default:     seg_last = 1'b0;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            // header checksum runs in ip_header_gen while we wait here
            ST_IDLE, ST_CHECK_SUM: if (hdr_ready) next_state = ST_PREAMBLE;
            ST_PREAMBLE: if (seg_last) next_state = ST_ETH_HEAD;
            ST_ETH_HEAD: if (seg_last) next_state = ST_IP_HEAD;
            ST_IP_HEAD:  if (seg_last) next_state = ST_TX_DATA;
            ST_TX_DATA:  if (seg_last) next_state = ST_CRC;
            ST_CRC:      if (seg_last) next_state = ST_IDLE;
            default:     next_state = ST_IDLE;
        endcase
    end

    // index of the byte that goes out on the next edge
    assign seg_change = (next_state != state);
    assign cnt_nxt    = (seg_change || next_state == ST_IDLE) ? 5'd0 : byte_cnt + 5'd1;
    assign dcnt_nxt   = (next_state == ST_TX_DATA && !seg_change) ? data_cnt + 16'd1 : '0;
    assign byte_sel   = (next_state == ST_TX_DATA) ? dcnt_nxt[1:0] : cnt_nxt[1:0];
    assign hdr_sel    = cnt_nxt[4:2];

    // ********************
    // byte mux
    // ********************
    always_comb begin
        case (next_state)
            ST_PREAMBLE: txd_nxt = (cnt_nxt == 5'(PREAMBLE_LEN - 1)) ? SFD_BYTE : PREAMBLE_BYTE;
            ST_ETH_HEAD: txd_nxt = eth_hdr[8 * (ETH_HEAD_LEN - 1 - int'(cnt_nxt)) +: 8];
            ST_IP_HEAD:  txd_nxt = hdr_word[8 * (3 - int'(byte_sel)) +: 8];   // msb first
            // payload lsb first, zero pad past n
            ST_TX_DATA:  txd_nxt = (dcnt_nxt < data_num) ? tx_data[8 * byte_sel +: 8] : '0;
            // reflected register, so low byte goes out first as is
            ST_CRC:      txd_nxt = ~crc_value[8 * byte_sel +: 8];
            default:     txd_nxt = '0;
        endcase
    end

    // request the next word while byte 2 of the current one is out
    assign req_nxt = (next_state == ST_IP_HEAD && cnt_nxt == 5'(IP_HEAD_WORDS * 4 - 2)) ||
                     (next_state == ST_TX_DATA && byte_sel == 2'd2 &&
                      dcnt_nxt + 16'd2 < data_num);

    assign done_nxt = (state == ST_CRC) && seg_last;

    // crc sees each byte as it is registered onto gmii_txd
    assign crc_en   = (next_state inside {ST_ETH_HEAD, ST_IP_HEAD, ST_TX_DATA});
    assign crc_byte = txd_nxt;
    assign busy     = (state != ST_IDLE);

    // ********************
    // registers
    // ********************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            byte_cnt   <= 5'd0;
            data_cnt   <= '0;
            tx_req     <= 1'b0;
            tx_done    <= 1'b0;
            crc_clr    <= 1'b0;
            gmii_tx_en <= 1'b0;
            gmii_txd   <= '0;
        end else begin
            state      <= next_state;
            byte_cnt   <= cnt_nxt;
            data_cnt   <= dcnt_nxt;
            tx_req     <= req_nxt;
            tx_done    <= done_nxt;   // one cycle after the last fcs byte
            crc_clr    <= done_nxt;
            gmii_tx_en <= (next_state != ST_IDLE);
            gmii_txd   <= txd_nxt;
        end
    end

endmodule

//--- rtl/udp_tx.sv
module udp_tx (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              tx_start_en,
    input  udp_tx_pkg::word_t tx_data,
    input  udp_tx_pkg::len_t  tx_byte_num,
    input  udp_tx_pkg::mac_t  des_mac,
    input  udp_tx_pkg::ip_t   des_ip,
    output logic              tx_req,
    output logic              tx_done,
    output logic              gmii_tx_en,
    output udp_tx_pkg::byte_t gmii_txd
);
    import udp_tx_pkg::*;

    logic       start_d0;
    logic       start_d1;
    logic       start;
    logic       busy;
    logic       hdr_ready;
    logic [2:0] hdr_sel;
    word_t      hdr_word;
    mac_t       dst_mac;
    len_t       data_num;
    logic       crc_en;
    logic       crc_clr;
    byte_t      crc_byte;
    crc_t       crc_value;

    // ********************
    // start edge
    // ********************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_d0 <= 1'b0;
            start_d1 <= 1'b0;
            start    <= 1'b0;
        end else begin
            start_d0 <= tx_start_en;
            start_d1 <= start_d0;
            start    <= start_d0 && !start_d1 && !busy;   // dropped mid frame
        end
    end

    ip_header_gen ip_header_gen_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .tx_byte_num (tx_byte_num),
        .des_mac     (des_mac),
        .des_ip      (des_ip),
        .hdr_sel     (hdr_sel),
        .hdr_word    (hdr_word),
        .dst_mac     (dst_mac),
        .data_num    (data_num),
        .hdr_ready   (hdr_ready)
    );

    udp_frame_fsm udp_frame_fsm_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .hdr_ready  (hdr_ready),
        .hdr_word   (hdr_word),
        .dst_mac    (dst_mac),
        .data_num   (data_num),
        .tx_data    (tx_data),
        .crc_value  (crc_value),
        .hdr_sel    (hdr_sel),
        .busy       (busy),
        .tx_req     (tx_req),
        .tx_done    (tx_done),
        .gmii_tx_en (gmii_tx_en),
        .gmii_txd   (gmii_txd),
        .crc_en     (crc_en),
        .crc_byte   (crc_byte),
        .crc_clr    (crc_clr)
    );

    eth_crc32 eth_crc32_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .crc_en    (crc_en),
        .crc_clr   (crc_clr),
        .crc_byte  (crc_byte),
        .crc_value (crc_value)
    );

endmodule

//--- dv/udp_tx_ref.svh
`ifndef UDP_TX_REF_SVH
`define UDP_TX_REF_SVH

localparam logic [31:0] REF_POLY = 32'hedb8_8320;   // reflected 0x04C11DB7

// galois lfsr, one step per bit taken
function automatic logic [47:0] rand_bits(int nbits);
    logic [47:0] r;
    r = '0;
    for (int i = 0; i < nbits; i++) begin
        r[i]  = lfsr[0];
        lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
endfunction

function automatic logic [15:0] ip_checksum(logic [31:0] w0, logic [31:0] w1,
                                            logic [31:0] w2, logic [31:0] w3,
                                            logic [31:0] w4);
    logic [31:0] s;
    s = 32'(w0[31:16]) + 32'(w0[15:0]) + 32'(w1[31:16]) + 32'(w1[15:0])
      + 32'(w2[31:16]) + 32'(w2[15:0]) + 32'(w3[31:16]) + 32'(w3[15:0])
      + 32'(w4[31:16]) + 32'(w4[15:0]);
    s = 32'(s[31:16]) + 32'(s[15:0]);
    s = 32'(s[31:16]) + 32'(s[15:0]);   // second fold for the carry of the first
    return ~s[15:0];
endfunction

// bitwise crc over everything after the sfd
function automatic logic [31:0] fcs_of(int from);
    logic [31:0] c;
    logic        fb;
    c = '1;
    for (int i = from; i < exp_q.size(); i++) begin
        for (int b = 0; b < 8; b++) begin
            fb = c[0] ^ exp_q[i][b];
            c  = c >> 1;
            if (fb) c = c ^ REF_POLY;
        end
    end
    return ~c;
endfunction

function automatic void push_bytes(logic [47:0] v, int nbytes);
    for (int i = nbytes - 1; i >= 0; i--) exp_q.push_back(v[8*i +: 8]);   // msb first
endfunction

function automatic void build_expected(int n, logic [47:0] mac, logic [31:0] ip,
                                       logic [15:0] id);
    logic [31:0] w0, w1, w2, w3, w4;
    logic [31:0] fcs;
    w0 = {8'h45, 8'h00, 16'(n + 28)};
    w1 = {id, 16'h4000};
    w2 = {8'h40, 8'd17, 16'h0000};
    w3 = {8'd192, 8'd168, 8'd1, 8'd10};
    w4 = (ip != 0) ? ip : {8'd192, 8'd168, 8'd1, 8'd102};
    w2[15:0] = ip_checksum(w0, w1, w2, w3, w4);
    exp_q = {};
    for (int i = 0; i < 7; i++) exp_q.push_back(8'h55);
    exp_q.push_back(8'hd5);
    push_bytes((mac != 0) ? mac : 48'hffff_ffff_ffff, 6);
    push_bytes(48'h00_11_22_33_44_55, 6);
    push_bytes(48'h0800, 2);
    push_bytes(48'(w0), 4);
    push_bytes(48'(w1), 4);
    push_bytes(48'(w2), 4);
    push_bytes(48'(w3), 4);
    push_bytes(48'(w4), 4);
    push_bytes(48'({16'd1234, 16'd1234}), 4);
    push_bytes(48'({16'(n + 8), 16'h0000}), 4);
    for (int i = 0; i < ((n < 18) ? 18 : n); i++) begin
        exp_q.push_back((i < n) ? pay_w[i / 4][8 * (i % 4) +: 8] : 8'h00);
    end
    fcs = fcs_of(8);
    for (int i = 0; i < 4; i++) exp_q.push_back(fcs[8*i +: 8]);   // low byte first
endfunction

`endif

//--- dv/udp_tx_tb.sv
module udp_tx_tb;
    import udp_tx_pkg::*;

    localparam logic [31:0] SEED = 32'hf053;
    localparam int NUM_FRAMES = 9;
    localparam int NUM_TESTS  = NUM_FRAMES + 1;
    localparam int CYC_LIMIT  = NUM_TESTS * (40 + 74 + 64);

    logic clk = 1'b0;
    logic rst_n, tx_start_en, tx_req, tx_done, gmii_tx_en;
    word_t tx_data;
    len_t tx_byte_num;
    mac_t des_mac;
    ip_t des_ip;
    byte_t gmii_txd;

    logic [31:0] lfsr = SEED;
    word_t pay_w [16];
    byte_t exp_q [$];
    byte_t cap_q [$];
    int exp_req, req_cnt, frame_seq, last_seq, frames_checked, src_idx;
    int err_cnt, pass_cnt, fail_cnt, cyc;
    logic en_d;

    `include "udp_tx_ref.svh"

    always #20 clk = ~clk;

    udp_tx udp_tx_i (
        .clk(clk), .rst_n(rst_n), .tx_start_en(tx_start_en), .tx_data(tx_data),
        .tx_byte_num(tx_byte_num), .des_mac(des_mac), .des_ip(des_ip),
        .tx_req(tx_req), .tx_done(tx_done), .gmii_tx_en(gmii_tx_en), .gmii_txd(gmii_txd)
    );

    // ********************
    // source and capture
    // ********************
    always @(posedge clk) begin
        if (tx_done) src_idx <= 0;
        else if (tx_req) begin
            tx_data <= pay_w[src_idx % 16];   // word due two cycles after the request
            src_idx <= src_idx + 1;
        end
    end

    always @(posedge clk) begin
        en_d <= gmii_tx_en;
        if (gmii_tx_en && !en_d) begin
            cap_q = {};
            req_cnt = 0;
            frame_seq++;
        end
        if (gmii_tx_en) cap_q.push_back(gmii_txd);
        if (tx_req) req_cnt++;
    end

    // ********************
    // compare
    // ********************
    always @(posedge clk) begin
        int errs;
        if (tx_done) begin
            errs = 0;
            if (frame_seq == last_seq) begin
                $display("tx_done pulsed with no new frame");
                errs++;
            end
            if (gmii_tx_en) begin
                $display("error gmii_tx_en still high at tx_done: %h", gmii_tx_en);
                errs++;
            end
            // last fcs byte sits in the cycle just before tx_done
            if (!en_d) begin
                $display("tx_done came later than one cycle after the last frame byte");
                errs++;
            end
            if (cap_q.size() != exp_q.size()) begin
                $display("error gmii frame length got %h exp %h", cap_q.size(), exp_q.size());
                errs++;
            end
            for (int i = 0; i < cap_q.size() && i < exp_q.size(); i++) begin
                if (cap_q[i] != exp_q[i]) begin
                    if (errs < 6) $display("error gmii_txd byte %0d got %h exp %h", i,
                                           cap_q[i], exp_q[i]);
                    errs++;
                end
            end
            if (req_cnt != exp_req) begin
                $display("error tx_req count got %h exp %h", req_cnt, exp_req);
                errs++;
            end
            $display("frame %0d n=%0d: %s", frames_checked + 1, tx_byte_num,
                     (errs == 0) ? "ok" : "FAIL");
            if (errs == 0) pass_cnt++;
            else fail_cnt++;
            err_cnt += errs;
            last_seq = frame_seq;
            frames_checked++;
        end
    end

    always @(posedge clk) begin
        cyc++;
        if (cyc >= CYC_LIMIT) begin
            $display("timeout after %0d cycles, frames checked %0d", cyc, frames_checked);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic send_frame(int n, mac_t mac, ip_t ip, int idx);
        for (int i = 0; i < 16; i++) pay_w[i] = word_t'(rand_bits(32));
        build_expected(n, mac, ip, len_t'(idx + 1));   // id counts from 1
        exp_req = (n + 3) / 4;
        @(posedge clk);
        tx_byte_num <= len_t'(n);
        des_mac     <= mac;
        des_ip      <= ip;
        tx_start_en <= 1'b1;
        @(posedge clk);
        tx_start_en <= 1'b0;
        wait (frames_checked == idx + 1);
    endtask

    initial begin
        int errs;
        rst_n = 1'b0;
        tx_start_en = 1'b0;
        tx_data = '0;
        tx_byte_num = 16'd1;
        des_mac = '0;
        des_ip = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        errs = 0;
        repeat (10) begin
            @(negedge clk);
            if (gmii_tx_en || tx_req || tx_done || gmii_txd != 0) begin
                $display("error idle outputs en/req/done/txd: %h %h %h %h",
                         gmii_tx_en, tx_req, tx_done, gmii_txd);
                errs++;
            end
        end
        $display("reset: %s", (errs == 0) ? "ok" : "FAIL");
        if (errs == 0) pass_cnt++;
        else fail_cnt++;
        err_cnt += errs;

        send_frame(30, '0, '0, 0);                   // default addresses
        send_frame(5, '0, '0, 1);
        send_frame(18 + int'(rand_bits(6)) % 47, rand_bits(48) | 48'h1,
                   ip_t'(rand_bits(32)) | 32'h1, 2);  // override
        send_frame(18 + int'(rand_bits(6)) % 47, rand_bits(48) | 48'h1,
                   ip_t'(rand_bits(32)) | 32'h1, 3);
        for (int i = 4; i < 7; i++) send_frame(18 + int'(rand_bits(6)) % 47, '0, '0, i);
        for (int i = 7; i < NUM_FRAMES; i++) send_frame(1 + int'(rand_bits(5)) % 17, '0, '0, i);

        repeat (4) @(posedge clk);
        $display("tests %0d passed %0d failed %0d errors %0d", NUM_TESTS, pass_cnt,
                 fail_cnt, err_cnt);
        if (err_cnt == 0 && pass_cnt == NUM_TESTS) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+dv
rtl/udp_tx_pkg.sv
rtl/ip_header_gen.sv
rtl/eth_crc32.sv
rtl/udp_frame_fsm.sv
rtl/udp_tx.sv
dv/udp_tx_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the udp_tx testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f src.f --top-module udp_tx_tb -o udp_tx_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/udp_tx_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    exit 1
fi
exit 0
